//--- rtl/controller_defines.svh
`ifndef ControllerDefinesSvh
`define ControllerDefinesSvh

// Word and field widths
`define InsWidth        16
`define OpWidth         4
`define RegSelWidth     4
`define ImmByteWidth    8
`define PsrWidth        5
`define PcStepWidth     8
`define AluSelWidth     2
`define FlowKindWidth   3
`define CondWidth       3

// Status register flag positions
`define PsrFlagLow      0
`define PsrFlagZero     1
`define PsrFlagHigh     3

// ALU move as seen by the datapath
`define OpCodeMove      4'b0000
`define ExtMove         4'b1101

// Extension codes inside the memory, jump and register-flow groups
`define ExtLoad         4'h0
`define ExtStore        4'h1
`define ExtRegJump      4'h0
`define ExtStorePc      4'h1
`define ExtCondLast     4'h4
`define ExtJumpAlways   4'h5

// PC step sizes
`define StepNone        8'd0
`define StepOne         8'd1
`define StepTwo         8'd2

`endif

//--- rtl/ControllerPkg.sv
`include "controller_defines.svh"

package ControllerPkg;

    ////////////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////////////

    // Register form used by ALU, CMP, loads, stores and flow ops
    typedef struct packed
    {
        logic [`OpWidth-1:0]        opCode;
        logic [`OpWidth-1:0]        opExt;
        logic [`RegSelWidth-1:0]    srcA;
        logic [`RegSelWidth-1:0]    srcB;
    } regFormat;

    // Immediate form, byte sits between opcode and destination
    typedef struct packed
    {
        logic [`OpWidth-1:0]        opCode;
        logic [`ImmByteWidth-1:0]   immByte;
        logic [`RegSelWidth-1:0]    dest;
    } immFormat;

    // Same 16 bits, read either way depending on the opcode
    typedef union packed
    {
        regFormat regForm;
        immFormat immForm;
    } insWord;

    ////////////////////////////////////////////////////////////
    // Decode enums
    ////////////////////////////////////////////////////////////

    // Major opcode groups, top nibble of the word
    typedef enum logic [`OpWidth-1:0]
    {
        OpAlu     = 4'b0000,
        OpBranch  = 4'b0001,
        OpCmp     = 4'b0011,
        OpMem     = 4'b0100,
        OpAddI    = 4'b0101,
        OpAddUI   = 4'b0110,
        OpMovIU   = 4'b0111,
        OpMovI    = 4'b1000,
        OpSubI    = 4'b1001,
        OpJump    = 4'b1010,
        OpCmpI    = 4'b1011,
        OpRegFlow = 4'b1100,
        OpSystem  = 4'b1101
    } opClass;

    // Second ALU operand source
    typedef enum logic [`AluSelWidth-1:0]
    {
        Immediate      = 2'b00,
        RegA           = 2'b01,
        Memory         = 2'b10,
        ProgramCounter = 2'b11
    } aluSource;

    // How the PC moves this cycle
    typedef enum logic [`FlowKindWidth-1:0]
    {
        Hold,
        Step,
        Skip,
        Branch,
        RegJump
    } flowKind;

    // Encoded as the extension nibble of branch and jump words
    typedef enum logic [`CondWidth-1:0]
    {
        Ge     = 3'd0,
        Hs     = 3'd1,
        Eq     = 3'd2,
        Lt     = 3'd3,
        Ls     = 3'd4,
        Always = 3'd5
    } condCode;

endpackage

//--- rtl/InstructionDecoder.sv
`timescale 1ns/100ps
`include "controller_defines.svh"

module InstructionDecoder
(
    input  logic                        Clock,
    input  logic                        Reset,
    input  ControllerPkg::insWord       Ins,
    output logic [`OpWidth-1:0]         OpCode,
    output logic [`OpWidth-1:0]         OpExt,
    output logic                        RegWrite,
    output logic [`RegSelWidth-1:0]     RegIn,
    output logic [`RegSelWidth-1:0]     RegA,
    output logic [`RegSelWidth-1:0]     RegB,
    output logic [`InsWidth-1:0]        Immediate,
    output ControllerPkg::aluSource     SelAlu,
    output logic                        SelMem,
    output logic                        MemRw,
    output logic                        IrWrite,
    output logic                        PcReset,
    output logic                        IrReset,
    output logic                        PsrReset,
    output logic                        PsrEnable,
    output ControllerPkg::flowKind      Kind,
    output ControllerPkg::condCode      Cond,
    output logic [`PcStepWidth-1:0]     Offset
);

    // Low in fetch, high in execute
    logic executePhase;

    ControllerPkg::opClass      opGroup;
    logic [`ImmByteWidth-1:0]   immByte;
    logic [`InsWidth-1:0]       immSigned;
    logic [`InsWidth-1:0]       immUnsigned;
    logic [`InsWidth-1:0]       immHigh;

    ////////////////////////////////////////////////////////////
    // Phase register
    ////////////////////////////////////////////////////////////

    // Two cycles per instruction and never a stall
    always_ff @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
        begin
            executePhase <= 1'b0;
        end
        else
        begin
            executePhase <= !executePhase;
        end
    end

    // Field extraction
    assign opGroup = ControllerPkg::opClass'(Ins.regForm.opCode);
    assign immByte = Ins.immForm.immByte;

    // Three ways to widen the byte
    assign immSigned   = {{(`InsWidth-`ImmByteWidth){immByte[`ImmByteWidth-1]}}, immByte};
    assign immUnsigned = {{(`InsWidth-`ImmByteWidth){1'b0}}, immByte};
    assign immHigh     = {immByte, {(`InsWidth-`ImmByteWidth){1'b0}}};

    ////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // Idle values as shown in reset
        OpCode    = '0;
        OpExt     = '0;
        RegWrite  = 1'b0;
        RegIn     = '0;
        RegA      = '0;
        RegB      = '0;
        Immediate = '0;
        SelAlu    = ControllerPkg::Immediate;
        SelMem    = 1'b0;
        MemRw     = 1'b0;
        IrWrite   = 1'b0;
        PcReset   = 1'b0;
        IrReset   = 1'b0;
        PsrReset  = 1'b0;
        PsrEnable = 1'b0;
        Kind      = ControllerPkg::Hold;
        Cond      = ControllerPkg::Ge;
        Offset    = '0;

        if (Reset)
        begin
            // Active-low strobes released once out of reset
            PcReset  = 1'b1;
            IrReset  = 1'b1;
            PsrReset = 1'b1;

            if (!executePhase)
            begin
                // Fetch addresses memory by PC and loads the IR
                SelMem  = 1'b1;
                IrWrite = 1'b1;
            end
            else
            begin
                PsrEnable = 1'b1;
                // Anything not matched below is a plain step
                Kind = ControllerPkg::Step;

                case (opGroup)
                    ControllerPkg::OpAlu,
                    ControllerPkg::OpCmp:
                    begin
                        OpCode = Ins.regForm.opCode;
                        OpExt  = Ins.regForm.opExt;
                        RegA   = Ins.regForm.srcA;
                        RegB   = Ins.regForm.srcB;
                        SelAlu = ControllerPkg::RegA;
                        // CMP only touches the flags
                        if (opGroup == ControllerPkg::OpAlu)
                        begin
                            RegIn    = Ins.regForm.srcB;
                            RegWrite = 1'b1;
                        end
                    end

                    ControllerPkg::OpAddI,
                    ControllerPkg::OpAddUI,
                    ControllerPkg::OpMovIU,
                    ControllerPkg::OpMovI,
                    ControllerPkg::OpSubI,
                    ControllerPkg::OpCmpI:
                    begin
                        OpCode = Ins.immForm.opCode;
                        OpExt  = Ins.regForm.opExt;
                        RegB   = Ins.immForm.dest;
                        SelAlu = ControllerPkg::Immediate;
                        if (opGroup != ControllerPkg::OpCmpI)
                        begin
                            RegIn    = Ins.immForm.dest;
                            RegWrite = 1'b1;
                        end
                        // Widen per opcode
                        case (opGroup)
                            ControllerPkg::OpAddUI,
                            ControllerPkg::OpMovI:  Immediate = immUnsigned;
                            ControllerPkg::OpMovIU: Immediate = immHigh;
                            default:                Immediate = immSigned;
                        endcase
                    end

                    ControllerPkg::OpMem:
                    begin
                        if (Ins.regForm.opExt == `ExtLoad)
                        begin
                            // Memory data moved through the ALU into a register
                            OpCode   = `OpCodeMove;
                            OpExt    = `ExtMove;
                            RegB     = Ins.regForm.srcA;
                            RegIn    = Ins.regForm.srcB;
                            RegWrite = 1'b1;
                            SelAlu   = ControllerPkg::Memory;
                        end
                        else if (Ins.regForm.opExt == `ExtStore)
                        begin
                            // Address from RegB, data from RegA
                            OpCode  = `OpCodeMove;
                            OpExt   = `ExtMove;
                            RegA    = Ins.regForm.srcB;
                            RegB    = Ins.regForm.srcA;
                            SelAlu  = ControllerPkg::RegA;
                            MemRw   = 1'b1;
                            IrWrite = 1'b1;
                        end
                    end

                    ControllerPkg::OpBranch:
                    begin
                        // Conditional skip over the next word
                        if (Ins.regForm.opExt <= `ExtCondLast)
                        begin
                            Kind = ControllerPkg::Skip;
                            Cond = ControllerPkg::condCode'(Ins.regForm.opExt[`CondWidth-1:0]);
                        end
                    end

                    ControllerPkg::OpJump:
                    begin
                        if (Ins.regForm.opExt <= `ExtCondLast)
                        begin
                            Kind   = ControllerPkg::Branch;
                            Cond   = ControllerPkg::condCode'(Ins.regForm.opExt[`CondWidth-1:0]);
                            Offset = {Ins.regForm.srcA, Ins.regForm.srcB};
                        end
                        else if (Ins.regForm.opExt == `ExtJumpAlways)
                        begin
                            Kind   = ControllerPkg::Branch;
                            Cond   = ControllerPkg::Always;
                            Offset = {Ins.regForm.srcA, Ins.regForm.srcB};
                        end
                    end

                    ControllerPkg::OpRegFlow:
                    begin
                        if (Ins.regForm.opExt == `ExtRegJump)
                        begin
                            // Target register passed through the ALU to the PC
                            OpCode = `OpCodeMove;
                            OpExt  = `ExtMove;
                            RegA   = Ins.regForm.srcA;
                            SelAlu = ControllerPkg::RegA;
                            Kind   = ControllerPkg::RegJump;
                        end
                        else if (Ins.regForm.opExt == `ExtStorePc)
                        begin
                            OpCode   = `OpCodeMove;
                            OpExt    = `ExtMove;
                            RegIn    = Ins.regForm.srcB;
                            RegWrite = 1'b1;
                            SelAlu   = ControllerPkg::ProgramCounter;
                        end
                    end

                    default:
                    begin
                        Kind = ControllerPkg::Step;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Register file and memory are never written in the same cycle
    writeExclusive: assert property (@(posedge Clock) disable iff (!Reset)
        !(MemRw && RegWrite))
        else $error("MemRw and RegWrite both high");

    // Every fetch loads the IR
    fetchLoadsIr: assert property (@(posedge Clock) disable iff (!Reset)
        !executePhase |-> IrWrite)
        else $error("Fetch cycle without IrWrite");

endmodule

//--- rtl/FlowControl.sv
`timescale 1ns/100ps
`include "controller_defines.svh"

module FlowControl
(
    input  ControllerPkg::flowKind      Kind,
    input  ControllerPkg::condCode      Cond,
    input  logic [`PcStepWidth-1:0]     Offset,
    input  logic [`PsrWidth-1:0]        Psr,
    output logic [`PcStepWidth-1:0]     PcImmediate,
    output logic                        PcWrite,
    output logic                        PcIncrement
);

    logic flagLow;
    logic flagZero;
    logic flagHigh;
    logic condTrue;

    // Status flags used by the conditions
    assign flagLow  = Psr[`PsrFlagLow];
    assign flagZero = Psr[`PsrFlagZero];
    assign flagHigh = Psr[`PsrFlagHigh];

    ////////////////////////////////////////////////////////////
    // Condition evaluation
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (Cond)
            ControllerPkg::Ge:     condTrue = flagZero || flagLow;
            ControllerPkg::Hs:     condTrue = flagHigh || flagZero;
            ControllerPkg::Eq:     condTrue = flagZero;
            ControllerPkg::Lt:     condTrue = !flagZero && !flagLow;
            ControllerPkg::Ls:     condTrue = !flagHigh;
            ControllerPkg::Always: condTrue = 1'b1;
            default:               condTrue = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // PC step select
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        PcImmediate = `StepNone;
        PcWrite     = 1'b0;
        PcIncrement = 1'b0;

        case (Kind)
            ControllerPkg::Step:
            begin
                PcIncrement = 1'b1;
                PcImmediate = `StepOne;
            end
            ControllerPkg::Skip:
            begin
                // Condition false skips the next word
                PcIncrement = 1'b1;
                PcImmediate = condTrue ? `StepOne : `StepTwo;
            end
            ControllerPkg::Branch:
            begin
                PcIncrement = 1'b1;
                PcImmediate = condTrue ? Offset : `StepOne;
            end
            ControllerPkg::RegJump:
            begin
                // PC loaded from the ALU result
                PcWrite = 1'b1;
            end
            default:
            begin
                // Hold leaves the PC untouched
                PcWrite = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/ControllerTop.sv
`timescale 1ns/100ps
`include "controller_defines.svh"

module ControllerTop
(
    input  logic                        Clock,
    input  logic                        Reset,
    input  logic [`InsWidth-1:0]        Ins,
    input  logic [`PsrWidth-1:0]        Psr,
    output logic [`OpWidth-1:0]         OpCode,
    output logic [`OpWidth-1:0]         OpExt,
    output logic                        RegWrite,
    output logic [`RegSelWidth-1:0]     RegIn,
    output logic [`RegSelWidth-1:0]     RegA,
    output logic [`RegSelWidth-1:0]     RegB,
    output logic [`InsWidth-1:0]        Immediate,
    output logic [`PcStepWidth-1:0]     PcImmediate,
    output logic [`AluSelWidth-1:0]     SelAlu,
    output logic                        SelMem,
    output logic                        MemRw,
    output logic                        PcWrite,
    output logic                        PcIncrement,
    output logic                        PcReset,
    output logic                        IrReset,
    output logic                        IrWrite,
    output logic                        PsrReset,
    output logic                        PsrEnable
);

    // Flow request from decode to the PC stepper
    ControllerPkg::flowKind     decodeKind;
    ControllerPkg::condCode     decodeCond;
    logic [`PcStepWidth-1:0]    decodeOffset;

    ////////////////////////////////////////////////////////////
    // Phase and datapath decode
    ////////////////////////////////////////////////////////////

    InstructionDecoder decoder
    (
        .Clock      (Clock),
        .Reset      (Reset),
        .Ins        (Ins),
        .OpCode     (OpCode),
        .OpExt      (OpExt),
        .RegWrite   (RegWrite),
        .RegIn      (RegIn),
        .RegA       (RegA),
        .RegB       (RegB),
        .Immediate  (Immediate),
        .SelAlu     (SelAlu),
        .SelMem     (SelMem),
        .MemRw      (MemRw),
        .IrWrite    (IrWrite),
        .PcReset    (PcReset),
        .IrReset    (IrReset),
        .PsrReset   (PsrReset),
        .PsrEnable  (PsrEnable),
        .Kind       (decodeKind),
        .Cond       (decodeCond),
        .Offset     (decodeOffset)
    );

    // Status only matters for branch decisions
    FlowControl flow
    (
        .Kind           (decodeKind),
        .Cond           (decodeCond),
        .Offset         (decodeOffset),
        .Psr            (Psr),
        .PcImmediate    (PcImmediate),
        .PcWrite        (PcWrite),
        .PcIncrement    (PcIncrement)
    );

endmodule

//--- sim/ControllerTb.sv
`timescale 1ns/100ps
`include "controller_defines.svh"

module ControllerTb;

    localparam int ItemCount   = 400;
    localparam int ClockPeriod = 20;
    // Two cycles per item, doubled, plus slack for reset
    localparam int WatchdogTime = 2 * ItemCount * 2 * ClockPeriod + 20 * ClockPeriod;

    // Expected control outputs for one cycle
    typedef struct packed
    {
        logic [3:0]  opCode;
        logic [3:0]  opExt;
        logic        regWrite;
        logic [3:0]  regIn;
        logic [3:0]  regA;
        logic [3:0]  regB;
        logic [15:0] immediate;
        logic [7:0]  pcImmediate;
        logic [1:0]  selAlu;
        logic        selMem;
        logic        memRw;
        logic        pcWrite;
        logic        pcIncrement;
        logic        pcReset;
        logic        irReset;
        logic        irWrite;
        logic        psrReset;
        logic        psrEnable;
    } ctrlOutputs;

    logic                       Clock;
    logic                       Reset;
    logic [`InsWidth-1:0]       Ins;
    logic [`PsrWidth-1:0]       Psr;
    logic [`OpWidth-1:0]        OpCode;
    logic [`OpWidth-1:0]        OpExt;
    logic                       RegWrite;
    logic [`RegSelWidth-1:0]    RegIn;
    logic [`RegSelWidth-1:0]    RegA;
    logic [`RegSelWidth-1:0]    RegB;
    logic [`InsWidth-1:0]       Immediate;
    logic [`PcStepWidth-1:0]    PcImmediate;
    logic [`AluSelWidth-1:0]    SelAlu;
    logic                       SelMem;
    logic                       MemRw;
    logic                       PcWrite;
    logic                       PcIncrement;
    logic                       PcReset;
    logic                       IrReset;
    logic                       IrWrite;
    logic                       PsrReset;
    logic                       PsrEnable;

    // Phase as the testbench sees it, high in execute
    logic       tbExecute;
    ctrlOutputs expected;
    int         failCount;

    // Field groups compared by the checks
    logic [31:0] expDecode;
    logic [31:0] actDecode;
    logic [31:0] expImmediate;
    logic [31:0] actImmediate;
    logic [31:0] expEnables;
    logic [31:0] actEnables;
    logic [31:0] expStrobes;
    logic [31:0] actStrobes;
    logic [31:0] expPcControl;
    logic [31:0] actPcControl;

    ControllerTop DUT (.*);

    ////////////////////////////////////////////////////////////
    // Clock, phase and watchdog
    ////////////////////////////////////////////////////////////

    initial
    begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    // Fetch first after release, then toggles every edge
    always @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
        begin
            tbExecute <= 1'b0;
        end
        else
        begin
            tbExecute <= !tbExecute;
        end
    end

    initial
    begin
        #(WatchdogTime);
        $display("Watchdog expired before all items were driven");
        $display("Something failed");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // PSR bits: low 0, zero 1, high 3
    function automatic logic conditionHolds(input logic [2:0] cond, input logic [4:0] status);
        logic flagLow;
        logic flagZero;
        logic flagHigh;
        flagLow  = status[0];
        flagZero = status[1];
        flagHigh = status[3];
        case (cond)
            3'd0:    return flagZero || flagLow;
            3'd1:    return flagHigh || flagZero;
            3'd2:    return flagZero;
            3'd3:    return !flagZero && !flagLow;
            3'd4:    return !flagHigh;
            default: return 1'b1;
        endcase
    endfunction

    function automatic ctrlOutputs referenceOutputs(input logic inReset,
                                                    input logic inExecute,
                                                    input logic [15:0] word,
                                                    input logic [4:0] status);
        ctrlOutputs r;
        logic [3:0] op;
        logic [3:0] ext;
        logic [3:0] hiReg;
        logic [3:0] loReg;
        logic [7:0] imm8;
        r     = '0;
        op    = word[15:12];
        ext   = word[11:8];
        hiReg = word[7:4];
        loReg = word[3:0];
        imm8  = word[11:4];
        // Everything low holds the datapath in reset
        if (!inReset)
        begin
            return r;
        end
        r.pcReset  = 1'b1;
        r.irReset  = 1'b1;
        r.psrReset = 1'b1;
        if (!inExecute)
        begin
            r.selMem  = 1'b1;
            r.irWrite = 1'b1;
            return r;
        end
        r.psrEnable = 1'b1;
        // Plain step unless the opcode says otherwise
        r.pcIncrement = 1'b1;
        r.pcImmediate = 8'd1;
        case (op)
            4'h0, 4'h3:
            begin
                r.opCode = op;
                r.opExt  = ext;
                r.regA   = hiReg;
                r.regB   = loReg;
                r.selAlu = 2'b01;
                // CMP keeps the register file untouched
                if (op == 4'h0)
                begin
                    r.regIn    = loReg;
                    r.regWrite = 1'b1;
                end
            end
            4'h5, 4'h6, 4'h7, 4'h8, 4'h9, 4'hB:
            begin
                r.opCode = op;
                r.opExt  = ext;
                r.regB   = loReg;
                if (op != 4'hB)
                begin
                    r.regIn    = loReg;
                    r.regWrite = 1'b1;
                end
                if (op == 4'h6 || op == 4'h8)
                    r.immediate = {8'h00, imm8};
                else if (op == 4'h7)
                    r.immediate = {imm8, 8'h00};
                else
                    r.immediate = {{8{imm8[7]}}, imm8};
            end
            4'h4:
            begin
                if (ext == 4'h0)
                begin
                    // Load moves memory data into RegIn
                    r.opExt    = 4'hD;
                    r.regB     = hiReg;
                    r.regIn    = loReg;
                    r.regWrite = 1'b1;
                    r.selAlu   = 2'b10;
                end
                else if (ext == 4'h1)
                begin
                    r.opExt   = 4'hD;
                    r.regA    = loReg;
                    r.regB    = hiReg;
                    r.selAlu  = 2'b01;
                    r.memRw   = 1'b1;
                    r.irWrite = 1'b1;
                end
            end
            4'h1:
            begin
                // Skip one word when the condition fails
                if (ext <= 4'h4)
                    r.pcImmediate = conditionHolds(ext[2:0], status) ? 8'd1 : 8'd2;
            end
            4'hA:
            begin
                // Ext 5 is the offset jump, always taken
                if (ext <= 4'h5)
                    r.pcImmediate = conditionHolds(ext[2:0], status) ? word[7:0] : 8'd1;
            end
            4'hC:
            begin
                if (ext == 4'h0)
                begin
                    r.opExt       = 4'hD;
                    r.regA        = hiReg;
                    r.selAlu      = 2'b01;
                    r.pcWrite     = 1'b1;
                    r.pcIncrement = 1'b0;
                    r.pcImmediate = 8'd0;
                end
                else if (ext == 4'h1)
                begin
                    r.opExt    = 4'hD;
                    r.regIn    = loReg;
                    r.regWrite = 1'b1;
                    r.selAlu   = 2'b11;
                end
            end
            default:
            begin
                r.pcImmediate = 8'd1;
            end
        endcase
        return r;
    endfunction

    assign expected = referenceOutputs(Reset, tbExecute, Ins, Psr);

    assign expDecode    = {12'd0, expected.opCode, expected.opExt, expected.regIn,
                           expected.regA, expected.regB};
    assign actDecode    = {12'd0, OpCode, OpExt, RegIn, RegA, RegB};
    assign expImmediate = {16'd0, expected.immediate};
    assign actImmediate = {16'd0, Immediate};
    assign expEnables   = {26'd0, expected.regWrite, expected.selAlu, expected.selMem,
                           expected.memRw, expected.irWrite};
    assign actEnables   = {26'd0, RegWrite, SelAlu, SelMem, MemRw, IrWrite};
    assign expStrobes   = {28'd0, expected.pcReset, expected.irReset, expected.psrReset,
                           expected.psrEnable};
    assign actStrobes   = {28'd0, PcReset, IrReset, PsrReset, PsrEnable};
    assign expPcControl = {22'd0, expected.pcImmediate, expected.pcWrite, expected.pcIncrement};
    assign actPcControl = {22'd0, PcImmediate, PcWrite, PcIncrement};

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic reportMismatch(input string checkName,
                                  input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        failCount++;
        $display("FAILED %s expected %h actual %h at %0t", checkName, expVal, actVal, $time);
        $display("Something failed");
        $fatal(1);
    endtask

    // No disable on reset, the all-zero reset pattern is checked too
    decodeFields: assert property (@(posedge Clock) actDecode == expDecode)
        else reportMismatch("decodeFields", $sampled(expDecode), $sampled(actDecode));

    immediateValue: assert property (@(posedge Clock) actImmediate == expImmediate)
        else reportMismatch("immediateValue", $sampled(expImmediate), $sampled(actImmediate));

    // RegWrite, SelAlu, SelMem, MemRw, IrWrite
    writeEnables: assert property (@(posedge Clock) actEnables == expEnables)
        else reportMismatch("writeEnables", $sampled(expEnables), $sampled(actEnables));

    resetStrobes: assert property (@(posedge Clock) actStrobes == expStrobes)
        else reportMismatch("resetStrobes", $sampled(expStrobes), $sampled(actStrobes));

    pcControls: assert property (@(posedge Clock) actPcControl == expPcControl)
        else reportMismatch("pcControls", $sampled(expPcControl), $sampled(actPcControl));

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Mostly kept groups, extensions biased into range
    function automatic logic [15:0] randomWord();
        logic [31:0] bits;
        logic [3:0]  op;
        logic [3:0]  ext;
        bits = $urandom;
        if (bits[31:30] == 2'b11)
        begin
            op = bits[29:26];
        end
        else
        begin
            case (bits[29:26])
                4'd0:           op = 4'h0;
                4'd1:           op = 4'h3;
                4'd2:           op = 4'h5;
                4'd3:           op = 4'h6;
                4'd4:           op = 4'h7;
                4'd5:           op = 4'h8;
                4'd6:           op = 4'h9;
                4'd7:           op = 4'hB;
                4'd8, 4'd9:     op = 4'h1;
                4'd10, 4'd11:   op = 4'hA;
                4'd12, 4'd13:   op = 4'h4;
                default:        op = 4'hC;
            endcase
        end
        case (op)
            4'h1, 4'hA:
                ext = {1'b0, bits[25:23]};
            4'h4, 4'hC:
                ext = (bits[25:24] == 2'b11) ? bits[23:20] : {3'b000, bits[24]};
            default:
                ext = bits[25:22];
        endcase
        return {op, ext, bits[7:0]};
    endfunction

    initial
    begin
        logic [31:0] statusBits;
        failCount = 0;
        Reset     = 1'b0;
        Ins       = '0;
        Psr       = '0;
        void'($urandom(32'h6c3cba6a));

        repeat (4) @(posedge Clock);
        Reset <= 1'b1;

        // One instruction per fetch/execute pair
        for (int item = 0; item < ItemCount; item++)
        begin
            @(posedge Clock);
            statusBits = $urandom;
            Ins <= randomWord();
            Psr <= statusBits[4:0];
            @(posedge Clock);
        end
        repeat (2) @(posedge Clock);

        if (failCount == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/ControllerPkg.sv
rtl/InstructionDecoder.sv
rtl/FlowControl.sv
rtl/ControllerTop.sv
sim/ControllerTb.sv

//--- run.sh
#!/bin/sh
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module ControllerTb \
    -Mdir obj_dir -o ControllerSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ControllerSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation did not pass"
exit 1
